// File: Makefile
# Verilator build and run of the rx_majority testbench.

VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG ?= Something failed
PASS_MSG ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb.f
+incdir+verilog
verilog/rx_majority_pkg.sv
verilog/rx_frame_filter.sv
verilog/rx_majority.sv
verilog/rx_majority_wrapper.sv
test/tb_checker.sv
test/tb_top.sv

// File: test/tb_checker.sv
`timescale 1ns/1ps
`include "rx_majority_defs.svh"

module tb_checker #(
	parameter int NAME_W = 160
) (
	input logic clk125MHz,
	input logic reset,
	input logic note,
	input rx_majority_pkg::segment_t note_seg,
	input rx_majority_pkg::copy_id_t note_copy,
	input rx_majority_pkg::redundancy_t note_red,
	input logic note_hdr_ok,
	input logic [`RX_PAYLOAD_LEN*8-1:0] note_payload,
	input logic [NAME_W-1:0] note_name,
	input logic en_out,
	input rx_majority_pkg::byte_t data_out,
	input logic loss_detected,
	output int pending,
	output int data_errors,
	output int loss_errors,
	output int burst_errors
);
	import rx_majority_pkg::*;

	localparam int LEN = `RX_PAYLOAD_LEN;
	localparam int SEG_COUNT = `RX_SEGMENT_COUNT;

	// reference copy store with three buffers per slot.
	logic [LEN*8-1:0] model_buf [SEG_COUNT][3];
	logic [2:0] model_seen [SEG_COUNT];

	// expected bursts in the order they must leave the DUT.
	logic [LEN*8-1:0] exp_data [$];
	logic exp_loss [$];
	logic [NAME_W-1:0] exp_name [$];

	logic [LEN*8-1:0] cur_data;
	logic cur_loss;
	logic [NAME_W-1:0] cur_name;
	logic cur_valid;
	int idx;

	// each result bit takes the value held by at least two of the three copies.
	function automatic logic [LEN*8-1:0] majority(input logic [LEN*8-1:0] a,
		input logic [LEN*8-1:0] b, input logic [LEN*8-1:0] c);
		logic [LEN*8-1:0] r;
		int ones;
		for (int i = 0; i < LEN*8; i++) begin
			ones = int'(a[i]) + int'(b[i]) + int'(c[i]);
			r[i] = (ones >= 2);
		end
		return r;
	endfunction

	// ************************************************************
	// voting model that runs once for each frame sent.
	// ************************************************************
	task automatic model_frame();
		int s;
		int c;
		logic lost;
		s = int'(note_seg);
		c = int'(note_copy);
		if (!note_hdr_ok || s >= SEG_COUNT || c >= int'(note_red)) begin
			return;
		end
		if (c == 0) begin
			for (int k = 0; k < 3; k++) begin
				model_buf[s][k] = note_payload;
			end
			model_seen[s] = 3'b001;
		end else begin
			model_buf[s][c] = note_payload;
			model_seen[s][c] = 1'b1;
		end
		// the last copy of the set triggers the vote.
		if (c == int'(note_red) - 1) begin
			lost = 1'b0;
			for (int i = 0; i < int'(note_red); i++) begin
				if (!model_seen[s][i]) begin
					lost = 1'b1;
				end
			end
			exp_data.push_back(majority(model_buf[s][0], model_buf[s][1], model_buf[s][2]));
			exp_loss.push_back(lost);
			exp_name.push_back(note_name);
			model_seen[s] = 3'b000;
		end
	endtask

	task automatic check_output();
		byte_t exp_byte;
		logic exp_flag;
		if (en_out) begin
			if (idx == 0) begin
				cur_valid = (exp_loss.size() != 0);
				if (cur_valid) begin
					cur_data = exp_data.pop_front();
					cur_loss = exp_loss.pop_front();
					cur_name = exp_name.pop_front();
				end else begin
					$display("en_out raised a burst with no voted segment expected");
					burst_errors++;
				end
			end
			exp_byte = cur_data[8*idx +: 8];
			exp_flag = (idx == 0) ? cur_loss : 1'b0;
			if (cur_valid && data_out !== exp_byte) begin
				$display("FAILED %s: data_out byte %0d expected %02h actual %02h",
					cur_name, idx, exp_byte, data_out);
				data_errors++;
			end
			if (cur_valid && loss_detected !== exp_flag) begin
				$display("FAILED %s: loss_detected on byte %0d expected %0b actual %0b",
					cur_name, idx, exp_flag, loss_detected);
				loss_errors++;
			end
			idx = (idx == LEN - 1) ? 0 : idx + 1;
		end else begin
			if (idx != 0) begin
				$display("burst on en_out ended after %0d of %0d bytes", idx, LEN);
				burst_errors++;
				idx = 0;
			end
			if (loss_detected) begin
				$display("loss_detected pulsed while en_out was low");
				loss_errors++;
			end
		end
	endtask

	always @(posedge clk125MHz) begin
		if (reset) begin
			for (int s = 0; s < SEG_COUNT; s++) begin
				model_seen[s] = 3'b000;
				for (int k = 0; k < 3; k++) begin
					model_buf[s][k] = '0;
				end
			end
			idx = 0;
			cur_valid = 1'b0;
			pending <= 0;
		end else begin
			if (note) begin
				model_frame();
			end
			check_output();
			pending <= exp_loss.size() + ((idx != 0) ? 1 : 0);
		end
	end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps
`include "rx_majority_defs.svh"

module tb_top;
	import rx_majority_pkg::*;

	localparam int LEN = `RX_PAYLOAD_LEN;
	localparam int PAYLOAD_OFS = `RX_SEG_NUM_OFS + 4;
	localparam int FRAME_LEN = PAYLOAD_OFS + LEN;
	localparam int NAME_W = 160;
	localparam int ROWS = 24;
	// redundancy moves inside the header after the previous frame has been voted.
	localparam int RED_SWITCH = 16;
	localparam int DRAIN_TIMEOUT = 400;
	localparam int QUIET_CYCLES = 4 + LEN + 2;
	localparam int HDR_OK = 0;
	localparam int BAD_MAC = 1;
	localparam int BAD_IP = 2;
	localparam int BAD_MAGIC = 3;

	typedef struct packed {
		logic [NAME_W-1:0] name;
		segment_t seg;
		copy_id_t copy;
		redundancy_t red;
		logic [1:0] corrupt;
		byte_t flip;
		logic [1:0] sel;
	} stim_row_t;

	logic clk125MHz = 1'b0;
	logic reset = 1'b1;
	byte_t rx_data;
	logic rx_enable;
	redundancy_t redundancy;
	logic en_out;
	byte_t data_out;
	logic loss_detected;

	logic note;
	segment_t note_seg;
	copy_id_t note_copy;
	redundancy_t note_red;
	logic note_hdr_ok;
	logic [LEN*8-1:0] note_payload;
	logic [NAME_W-1:0] note_name;
	int pending;
	int data_errors;
	int loss_errors;
	int burst_errors;
	int timeouts;

	stim_row_t stim [ROWS];
	logic [LEN*8-1:0] payload_pool [4];
	byte_t frame_bytes [FRAME_LEN];
	logic [LEN*8-1:0] frame_payload;
	logic [31:0] rng = 32'd88;

	always #4 clk125MHz = ~clk125MHz;

	rx_majority_wrapper i_dut (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_enable(rx_enable),
		.redundancy(redundancy),
		.en_out(en_out),
		.data_out(data_out),
		.loss_detected(loss_detected)
	);

	tb_checker #(
		.NAME_W(NAME_W)
	) i_checker (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.note(note),
		.note_seg(note_seg),
		.note_copy(note_copy),
		.note_red(note_red),
		.note_hdr_ok(note_hdr_ok),
		.note_payload(note_payload),
		.note_name(note_name),
		.en_out(en_out),
		.data_out(data_out),
		.loss_detected(loss_detected),
		.pending(pending),
		.data_errors(data_errors),
		.loss_errors(loss_errors),
		.burst_errors(burst_errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic set_row(input int n, input logic [NAME_W-1:0] name, input int seg,
		input int copy, input int red, input int corrupt, input byte_t flip, input int sel);
		stim[n].name = name;
		stim[n].seg = segment_t'(seg);
		stim[n].copy = copy_id_t'(copy);
		stim[n].red = redundancy_t'(red);
		stim[n].corrupt = 2'(corrupt);
		stim[n].flip = flip;
		stim[n].sel = 2'(sel);
	endtask

	// ************************************************************
	// stimulus table.
	// ************************************************************
	task automatic fill_stim();
		set_row(0, "identical", 0, 0, 3, HDR_OK, 8'h00, 0);
		set_row(1, "identical", 0, 1, 3, HDR_OK, 8'h00, 0);
		set_row(2, "identical", 0, 2, 3, HDR_OK, 8'h00, 0);
		set_row(3, "outvoted", 1, 0, 3, HDR_OK, 8'h00, 1);
		set_row(4, "outvoted", 1, 1, 3, HDR_OK, 8'h5a, 1);
		set_row(5, "outvoted", 1, 2, 3, HDR_OK, 8'h00, 1);
		set_row(6, "missing copy", 2, 0, 3, HDR_OK, 8'h00, 2);
		set_row(7, "missing copy", 2, 2, 3, HDR_OK, 8'h00, 3);
		set_row(8, "redundancy one", 3, 0, 1, HDR_OK, 8'h00, 0);
		set_row(9, "redundancy one", 3, 0, 1, HDR_OK, 8'h00, 2);
		set_row(10, "redundancy one", 3, 1, 1, HDR_OK, 8'h00, 1);
		// a stored copy 1 from the frame above would outvote the copy-0 payload here.
		set_row(11, "redundancy one", 3, 2, 3, HDR_OK, 8'h00, 3);
		set_row(12, "header reject", 0, 0, 3, HDR_OK, 8'h00, 3);
		set_row(13, "header reject", 0, 1, 3, HDR_OK, 8'h00, 3);
		set_row(14, "header reject", 0, 2, 3, BAD_MAC, 8'h00, 3);
		set_row(15, "header reject", 0, 2, 3, BAD_IP, 8'h00, 3);
		set_row(16, "header reject", 0, 2, 3, BAD_MAGIC, 8'h00, 3);
		set_row(17, "header reject", 4, 2, 3, HDR_OK, 8'h00, 3);
		set_row(18, "interleaved", 1, 0, 3, HDR_OK, 8'h00, 2);
		set_row(19, "interleaved", 2, 0, 3, HDR_OK, 8'h00, 3);
		set_row(20, "interleaved", 1, 1, 3, HDR_OK, 8'h00, 2);
		set_row(21, "interleaved", 2, 1, 3, HDR_OK, 8'h00, 3);
		set_row(22, "interleaved", 2, 2, 3, HDR_OK, 8'h81, 3);
		set_row(23, "interleaved", 1, 2, 3, HDR_OK, 8'h00, 2);
	endtask

	task automatic make_payloads();
		for (int p = 0; p < 4; p++) begin
			for (int w = 0; w < LEN / 4; w++) begin
				rng = xorshift32(rng);
				payload_pool[p][32*w +: 32] = rng;
			end
		end
	endtask

	task automatic build_frame(input stim_row_t row);
		logic [47:0] mac;
		logic [31:0] ip;
		logic [15:0] magic;
		mac = `RX_DST_MAC;
		ip = `RX_SRC_IP;
		magic = `RX_MAGIC;
		for (int n = 0; n < FRAME_LEN; n++) begin
			frame_bytes[n] = byte_t'(8'h40 + n);
		end
		for (int n = 0; n < 6; n++) begin
			frame_bytes[`RX_DST_MAC_OFS + n] = mac[47 - 8*n -: 8];
		end
		for (int n = 0; n < 4; n++) begin
			frame_bytes[`RX_SRC_IP_OFS + n] = ip[31 - 8*n -: 8];
		end
		frame_bytes[`RX_MAGIC_OFS] = magic[15:8];
		frame_bytes[`RX_MAGIC_OFS + 1] = magic[7:0];
		case (int'(row.corrupt))
			BAD_MAC: frame_bytes[`RX_DST_MAC_OFS] ^= 8'h01;
			BAD_IP: frame_bytes[`RX_SRC_IP_OFS + 1] ^= 8'h10;
			BAD_MAGIC: frame_bytes[`RX_MAGIC_OFS + 1] ^= 8'h80;
			default: ;
		endcase
		frame_bytes[`RX_SEG_NUM_OFS] = row.seg[15:8];
		frame_bytes[`RX_SEG_NUM_OFS + 1] = row.seg[7:0];
		frame_bytes[`RX_SEG_NUM_OFS + 2] = byte_t'(row.copy);
		frame_bytes[`RX_SEG_NUM_OFS + 3] = 8'ha5;
		frame_payload = payload_pool[row.sel];
		frame_payload[31:24] ^= row.flip;
		for (int n = 0; n < LEN; n++) begin
			frame_bytes[PAYLOAD_OFS + n] = frame_payload[8*n +: 8];
		end
	endtask

	// the checker hears about each frame with its first byte.
	task automatic send_frame(input stim_row_t row);
		note_seg = row.seg;
		note_copy = row.copy;
		note_red = row.red;
		note_hdr_ok = (row.corrupt == 2'(HDR_OK));
		note_payload = frame_payload;
		note_name = row.name;
		for (int n = 0; n < FRAME_LEN; n++) begin
			rx_enable = 1'b1;
			rx_data = frame_bytes[n];
			note = (n == 0);
			if (n == RED_SWITCH) begin
				redundancy = row.red;
			end
			@(posedge clk125MHz);
			#1;
		end
		rx_enable = 1'b0;
		rx_data = '0;
		note = 1'b0;
		repeat (2) begin
			@(posedge clk125MHz);
			#1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk125MHz);
			#1;
			waited++;
		end
		if (pending != 0) begin
			$display("timeout: %0d voted segments never appeared on en_out", pending);
			timeouts++;
		end
	endtask

	initial begin
		rx_data = '0;
		rx_enable = 1'b0;
		note = 1'b0;
		note_seg = '0;
		note_copy = '0;
		note_red = '0;
		note_hdr_ok = 1'b0;
		note_payload = '0;
		note_name = '0;
		timeouts = 0;
		fill_stim();
		make_payloads();
		redundancy = stim[0].red;
		repeat (8) @(posedge clk125MHz);
		#1;
		reset = 1'b0;

		for (int r = 0; r < ROWS; r++) begin
			build_frame(stim[r]);
			send_frame(stim[r]);
		end
		wait_drain();
		// window for a stray burst from the last frame.
		for (int n = 0; n < QUIET_CYCLES; n++) begin
			@(posedge clk125MHz);
		end
		#1;

		$display("errors: data %0d, loss %0d, burst %0d, timeout %0d",
			data_errors, loss_errors, burst_errors, timeouts);
		if (data_errors + loss_errors + burst_errors + timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: verilog/rx_frame_filter.sv
`timescale 1ns/1ps
`include "rx_majority_defs.svh"

module rx_frame_filter (
	input logic clk125MHz,
	input logic reset,
	input rx_majority_pkg::byte_t rx_data,
	input logic rx_enable,
	output rx_majority_pkg::seg_write_t seg_write
);
	import rx_majority_pkg::*;

	localparam int COPY_OFS = `RX_SEG_NUM_OFS + 2;
	localparam int PAYLOAD_OFS = `RX_SEG_NUM_OFS + 4;
	localparam int LAST_OFS = PAYLOAD_OFS + `RX_PAYLOAD_LEN - 1;
	localparam logic [47:0] DST_MAC = `RX_DST_MAC;
	localparam logic [31:0] SRC_IP = `RX_SRC_IP;
	localparam logic [15:0] MAGIC = `RX_MAGIC;

	byte_t rx_data_q;
	logic rx_enable_q;
	logic [11:0] count;
	logic valid;
	segment_t seg_num;
	copy_id_t copy_num;
	byte_t expected;
	logic check_en;
	logic in_payload;
	logic seg_ok;

	// payload byte waiting for the segment range check.
	logic pl_wr;
	logic pl_last;
	payload_idx_t pl_offset;
	byte_t pl_data;

	always_ff @(posedge clk125MHz) begin
		rx_data_q <= rx_data;
		if (reset) begin
			rx_enable_q <= 1'b0;
		end else begin
			rx_enable_q <= rx_enable;
		end
	end

	// ********************************************************
	// header check, count indexes the byte held in rx_data_q.
	// ********************************************************
	always_comb begin
		check_en = 1'b1;
		expected = '0;
		case (count)
			`RX_DST_MAC_OFS + 0: expected = DST_MAC[47:40];
			`RX_DST_MAC_OFS + 1: expected = DST_MAC[39:32];
			`RX_DST_MAC_OFS + 2: expected = DST_MAC[31:24];
			`RX_DST_MAC_OFS + 3: expected = DST_MAC[23:16];
			`RX_DST_MAC_OFS + 4: expected = DST_MAC[15:8];
			`RX_DST_MAC_OFS + 5: expected = DST_MAC[7:0];
			`RX_SRC_IP_OFS + 0: expected = SRC_IP[31:24];
			`RX_SRC_IP_OFS + 1: expected = SRC_IP[23:16];
			`RX_SRC_IP_OFS + 2: expected = SRC_IP[15:8];
			`RX_SRC_IP_OFS + 3: expected = SRC_IP[7:0];
			`RX_MAGIC_OFS + 0: expected = MAGIC[15:8];
			`RX_MAGIC_OFS + 1: expected = MAGIC[7:0];
			default: check_en = 1'b0;
		endcase
	end

	// count only while both enables are high, so the last byte ends the frame.
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			count <= '0;
			valid <= 1'b1;
		end else if (rx_enable_q && rx_enable) begin
			count <= count + 1'b1;
			if (check_en && rx_data_q != expected) begin
				valid <= 1'b0;
			end
			// copy index beyond two bits would alias a real copy.
			if (count == COPY_OFS && rx_data_q[7:2] != '0) begin
				valid <= 1'b0;
			end
		end else begin
			count <= '0;
			valid <= 1'b1;
		end
	end

	// segment number is sent high byte first.
	always_ff @(posedge clk125MHz) begin
		if (count == `RX_SEG_NUM_OFS) begin
			seg_num[15:8] <= rx_data_q;
		end
		if (count == `RX_SEG_NUM_OFS + 1) begin
			seg_num[7:0] <= rx_data_q;
		end
		if (count == COPY_OFS) begin
			copy_num <= rx_data_q[1:0];
		end
	end

	assign in_payload = rx_enable_q && count >= PAYLOAD_OFS && count <= LAST_OFS;
	assign seg_ok = seg_num < segment_t'(`RX_SEGMENT_COUNT);

	// ********************************************************
	// payload pipeline.
	// ********************************************************
	always_ff @(posedge clk125MHz) begin
		pl_data <= rx_data_q;
		pl_offset <= payload_idx_t'(count - PAYLOAD_OFS);
		pl_last <= (count == LAST_OFS);
		if (reset) begin
			pl_wr <= 1'b0;
		end else begin
			pl_wr <= in_payload && valid;
		end
	end

	always_ff @(posedge clk125MHz) begin
		seg_write.seg <= seg_num;
		seg_write.copy <= copy_num;
		seg_write.offset <= pl_offset;
		seg_write.data <= pl_data;
		if (reset) begin
			seg_write.wr <= 1'b0;
			seg_write.done <= 1'b0;
		end else begin
			seg_write.wr <= pl_wr && seg_ok;
			seg_write.done <= pl_wr && pl_last && seg_ok;
		end
	end

	// a write two stages on must come from a frame that was still valid.
	a_wr_valid: assert property (@(posedge clk125MHz) disable iff (reset)
		seg_write.wr |-> $past(valid, 2))
		else $error("payload write from an invalid frame");

endmodule

// File: verilog/rx_majority.sv
`timescale 1ns/1ps
`include "rx_majority_defs.svh"

module rx_majority #(
	parameter int SLOT = 0
) (
	input logic clk125MHz,
	input logic reset,
	input rx_majority_pkg::seg_write_t seg_write,
	input rx_majority_pkg::redundancy_t redundancy,
	output rx_majority_pkg::voter_out_t voter_out
);
	import rx_majority_pkg::*;

	localparam int LEN = `RX_PAYLOAD_LEN;
	localparam int IDX_W = $clog2(LEN);

	typedef enum logic {
		VOTE_IDLE,
		VOTE_BURST
	} vote_state_t;

	byte_t copy_buf [3][LEN];
	logic [2:0] seen;
	logic [2:0] seen_next;
	logic [2:0] need;
	logic hit;
	logic fire;
	logic loss_now;
	vote_state_t state;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] vote_idx;
	logic [IDX_W-1:0] wr_idx;
	byte_t vote_byte;

	// bytes for this slot from a copy the current redundancy counts.
	assign hit = seg_write.wr && seg_write.seg == segment_t'(SLOT) &&
		seg_write.copy < redundancy;
	assign wr_idx = seg_write.offset[IDX_W-1:0];

	// ********************************************************
	// copy bookkeeping.
	// ********************************************************
	always_comb begin
		seen_next = seen;
		if (hit) begin
			if (seg_write.copy == 2'd0) begin
				seen_next = 3'b001;
			end else begin
				seen_next[seg_write.copy] = 1'b1;
			end
		end
	end

	always_comb begin
		case (redundancy)
			2'd1: need = 3'b001;
			2'd2: need = 3'b011;
			2'd3: need = 3'b111;
			default: need = 3'b000;
		endcase
	end

	// vote once the last expected copy has finished.
	assign fire = hit && seg_write.done && seg_write.copy == redundancy - 2'd1;
	assign loss_now = |(need & ~seen_next);

	// copy 0 fills every buffer, so a missing copy votes like copy 0.
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			seen <= '0;
			for (int k = 0; k < 3; k++) begin
				for (int n = 0; n < LEN; n++) begin
					copy_buf[k][n] <= '0;
				end
			end
		end else begin
			if (hit) begin
				if (seg_write.copy == 2'd0) begin
					for (int k = 0; k < 3; k++) begin
						copy_buf[k][wr_idx] <= seg_write.data;
					end
				end else begin
					copy_buf[seg_write.copy][wr_idx] <= seg_write.data;
				end
			end
			seen <= fire ? 3'b000 : seen_next;
		end
	end

	// ********************************************************
	// majority vote and output burst.
	// ********************************************************
	// index of the byte loaded at the next edge.
	assign vote_idx = (state == VOTE_BURST) ? rd_idx + 1'b1 : '0;

	assign vote_byte = (copy_buf[0][vote_idx] & copy_buf[1][vote_idx]) |
		(copy_buf[0][vote_idx] & copy_buf[2][vote_idx]) |
		(copy_buf[1][vote_idx] & copy_buf[2][vote_idx]);

	always_ff @(posedge clk125MHz) begin
		voter_out.data <= vote_byte;
		if (reset) begin
			state <= VOTE_IDLE;
			rd_idx <= '0;
			voter_out.en <= 1'b0;
			voter_out.loss <= 1'b0;
		end else begin
			voter_out.loss <= fire && loss_now;
			case (state)
				VOTE_IDLE: begin
					if (fire) begin
						state <= VOTE_BURST;
						rd_idx <= '0;
						voter_out.en <= 1'b1;
					end
				end
				VOTE_BURST: begin
					// rd_idx is the byte now on the output.
					if (rd_idx == IDX_W'(LEN - 1)) begin
						state <= VOTE_IDLE;
						voter_out.en <= 1'b0;
					end else begin
						rd_idx <= rd_idx + 1'b1;
					end
				end
				default: state <= VOTE_IDLE;
			endcase
		end
	end

	// frame spacing keeps every frame end clear of a running burst.
	a_done_idle: assert property (@(posedge clk125MHz) disable iff (reset)
		seg_write.done |-> state == VOTE_IDLE)
		else $error("frame end during burst in slot %0d", SLOT);

	a_red_set: assert property (@(posedge clk125MHz) disable iff (reset)
		(seg_write.done && seg_write.seg == segment_t'(SLOT)) |-> redundancy != 2'd0)
		else $error("redundancy 0 at frame end in slot %0d", SLOT);

endmodule

// File: verilog/rx_majority_defs.svh
`ifndef RX_MAJORITY_DEFS_SVH
`define RX_MAJORITY_DEFS_SVH

// payload bytes per segment.
`define RX_PAYLOAD_LEN 16

// number of voter slots, higher segments are dropped.
`define RX_SEGMENT_COUNT 4

// byte offsets counted from the first byte of the frame.
`define RX_DST_MAC_OFS 6
`define RX_SRC_IP_OFS 26
`define RX_MAGIC_OFS 32

// segment number, then copy index at +2, aux byte at +3, payload at +4.
`define RX_SEG_NUM_OFS 34

// header match values.
`define RX_DST_MAC 48'hdead_beef_0123
`define RX_SRC_IP 32'hc0a8_0140
`define RX_MAGIC 16'h0102

`endif

// File: verilog/rx_majority_pkg.sv
package rx_majority_pkg;

	// one byte of the receive stream.
	typedef logic [7:0] byte_t;

	// segment number as carried in the frame header.
	typedef logic [15:0] segment_t;

	// copy index, only 0 to 2 are meaningful.
	typedef logic [1:0] copy_id_t;

	// number of copies sent per segment, 1 to 3.
	typedef logic [1:0] redundancy_t;

	// byte position inside the payload.
	typedef logic [7:0] payload_idx_t;

	// payload byte broadcast from the filter to every voter.
	typedef struct packed {
		logic wr;
		segment_t seg;
		copy_id_t copy;
		payload_idx_t offset;
		byte_t data;
		// last payload byte of a valid frame.
		logic done;
	} seg_write_t;

	// output of one voter slot.
	typedef struct packed {
		logic en;
		byte_t data;
		// set with the first byte of a burst only.
		logic loss;
	} voter_out_t;

endpackage

// File: verilog/rx_majority_wrapper.sv
`timescale 1ns/1ps
`include "rx_majority_defs.svh"

module rx_majority_wrapper (
	input logic clk125MHz,
	input logic reset,
	input rx_majority_pkg::byte_t rx_data,
	input logic rx_enable,
	input rx_majority_pkg::redundancy_t redundancy,
	output logic en_out,
	output rx_majority_pkg::byte_t data_out,
	output logic loss_detected
);
	import rx_majority_pkg::*;

	seg_write_t seg_write;
	voter_out_t voter_out [`RX_SEGMENT_COUNT];
	voter_out_t merged;
	logic [`RX_SEGMENT_COUNT-1:0] active;

	rx_frame_filter i_filter (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_enable(rx_enable),
		.seg_write(seg_write)
	);

	// ********************************************************
	// one voter per segment slot.
	// ********************************************************
	generate
		for (genvar i = 0; i < `RX_SEGMENT_COUNT; i++) begin : g_voter
			rx_majority #(
				.SLOT(i)
			) i_voter (
				.clk125MHz(clk125MHz),
				.reset(reset),
				.seg_write(seg_write),
				.redundancy(redundancy),
				.voter_out(voter_out[i])
			);

			assign active[i] = voter_out[i].en;
		end
	endgenerate

	// only one slot bursts at a time, so OR works as a select.
	always_comb begin
		merged = '0;
		for (int i = 0; i < `RX_SEGMENT_COUNT; i++) begin
			if (voter_out[i].en) begin
				merged.en = 1'b1;
				merged.data = merged.data | voter_out[i].data;
				merged.loss = merged.loss | voter_out[i].loss;
			end
		end
	end

	// output register.
	always_ff @(posedge clk125MHz) begin
		data_out <= merged.data;
		if (reset) begin
			en_out <= 1'b0;
			loss_detected <= 1'b0;
		end else begin
			en_out <= merged.en;
			loss_detected <= merged.loss;
		end
	end

	// bursts from different slots never overlap.
	a_one_slot: assert property (@(posedge clk125MHz) disable iff (reset)
		$onehot0(active))
		else $error("more than one voter active");

endmodule
